// File: filelist.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_if.sv
verilog/icache_lookup.sv
verilog/icache_refill_table.sv
verilog/icache_refill_ctrl.sv
verilog/icache_top.sv
tests/icache_checker.sv
tests/icache_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the pass message
verilator --binary --timing --assert -f filelist.f --top-module icache_tb -o icache_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1 ; cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/icache_checker.sv
// matches each response to open fetches by id and by the line address held in the data
// a test finishes once its fetch is acked and its response has been seen
`include "icache_params.svh"

module icache_checker (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      fetch_ack_i,
    input logic                      mem_req_i,
    input logic [`ICACHE_ADDR_W-1:0] mem_addr_i,
    input logic [`ICACHE_PEND_W-1:0] mem_idx_i,
    input logic                      mem_rsp_req_i,
    input logic [`ICACHE_PEND_W-1:0] mem_rsp_idx_i,
    input logic                      rsp_req_i,
    input logic [`ICACHE_LINE_W-1:0] rsp_data_i,
    input logic                      rsp_err_i,
    input logic [`ICACHE_IDS-1:0]    rsp_mask_i
);

    string                     name_q [64];
    logic [`ICACHE_ID_W-1:0]   id_q [64];
    logic [`ICACHE_ADDR_W-1:0] addr_q [64];
    bit                        err_q [64];
    int                        kind_q [64];
    int                        reqs_q [64];
    bit                        bad_q [64];
    bit                        rsp_seen_q [64];
    bit                        ack_seen_q [64];
    int started = 0;
    int answered = 0;
    int passed = 0;
    int failed = 0;
    int errors = 0;
    int inflight = 0;
    int cur;
    int want;
    logic ack_d = 1'b0;
    logic mreq_d = 1'b0;
    logic mrsp_d = 1'b0;
    logic rsp_d = 1'b0;
    // table indices handed out with a refill request and not yet answered by memory
    logic [`ICACHE_PENDING-1:0] busy = '0;

    // memory data is the line address repeated in every 12-bit field
    function automatic logic [`ICACHE_LINE_W-1:0] line_of(input logic [`ICACHE_ADDR_W-1:0] a);
        return {4'h0, a, a, a, a, a};
    endfunction

    function automatic int open_count();
        return started - answered;
    endfunction

    task automatic start_test(input int t, input string name, input logic [1:0] id,
                              input logic [11:0] addr, input bit err, input int kind);
        name_q[t] = name;
        id_q[t]   = id;
        addr_q[t] = addr;
        err_q[t]  = err;
        kind_q[t] = kind;
        started   = t + 1;
    endtask

    task automatic flag(input int t, input string what, input logic [63:0] exp,
                        input logic [63:0] act);
        bad_q[t] = 1'b1;
        $display("Fail %s: %s expected %0h actual %0h", name_q[t], what, exp, act);
    endtask

    task automatic close_if_done(input int t);
        if (rsp_seen_q[t] && ack_seen_q[t]) begin
            if (bad_q[t]) begin
                failed++;
                $display("%s: failed", name_q[t]);
            end else begin
                passed++;
                $display("%s: passed", name_q[t]);
            end
        end
    endtask

    task automatic answer(input logic [`ICACHE_ID_W-1:0] id);
        int t;
        t = -1;
        for (int i = 0; i < started; i++)
            if (t < 0 && !rsp_seen_q[i] && id_q[i] == id
                && addr_q[i] == rsp_data_i[`ICACHE_ADDR_W-1:0])
                t = i;
        if (t < 0) begin
            errors++;
            $display("no open fetch of id %0d matches a response for line %h",
                     id, rsp_data_i[`ICACHE_ADDR_W-1:0]);
        end else begin
            if (rsp_data_i !== line_of(addr_q[t]))
                flag(t, "data", line_of(addr_q[t]), rsp_data_i);
            if (rsp_err_i !== err_q[t])
                flag(t, "error flag", 64'(err_q[t]), 64'(rsp_err_i));
            // a merged fetch shares its response with the fetch that allocated the refill
            if (kind_q[t] == 2 && $countones(rsp_mask_i) < 2)
                flag(t, "ids in mask", 64'(2), 64'($countones(rsp_mask_i)));
            rsp_seen_q[t] = 1'b1;
            answered++;
            close_if_done(t);
        end
    endtask

    task automatic print_counts();
        $display("%0d tests, %0d passed, %0d failed, %0d other errors",
                 started, passed, failed, errors);
    endtask

    always @(posedge clk_i) begin
        cur = started - 1;
        if (rst_ni && cur >= 0) begin
            if (mem_req_i && !mreq_d) begin
                if (inflight >= `ICACHE_PENDING) begin
                    errors++;
                    $display("%s: a refill was requested with four refills pending", name_q[cur]);
                end
                if (busy[mem_idx_i]) begin
                    errors++;
                    $display("%s: refill index %0d was handed out while still in flight",
                             name_q[cur], mem_idx_i);
                end
                busy[mem_idx_i] = 1'b1;
                inflight++;
                reqs_q[cur]++;
                if (mem_addr_i !== addr_q[cur])
                    flag(cur, "refill address", 64'(addr_q[cur]), 64'(mem_addr_i));
            end
            if (mem_rsp_req_i && !mrsp_d) begin
                inflight--;
                busy[mem_rsp_idx_i] = 1'b0;
            end
            if (fetch_ack_i && !ack_d) begin
                want = kind_q[cur] == 0 ? 1 : 0;
                if (reqs_q[cur] != want)
                    flag(cur, "refill requests", 64'(want), 64'(reqs_q[cur]));
                ack_seen_q[cur] = 1'b1;
                close_if_done(cur);
            end
            if (rsp_req_i && !rsp_d) begin
                if (rsp_mask_i == '0) begin
                    errors++;
                    $display("a response arrived with an empty id mask");
                end
                for (int i = 0; i < `ICACHE_IDS; i++)
                    if (rsp_mask_i[i])
                        answer(2'(i));
            end
        end
        ack_d  = fetch_ack_i;
        mreq_d = mem_req_i;
        mrsp_d = mem_rsp_req_i;
        rsp_d  = rsp_req_i;
    end

endmodule

// File: tests/icache_input.txt
# name id addr(hex) mem_delay err ack_delay kind
# kind 0 = new refill, 1 = hit, 2 = merge into a pending refill
cold_a     0 104 20 0 0 0
merge_a    1 104 20 0 1 2
cold_b     2 235 4  0 3 0
hit_a      3 104 0  0 1 1
hit_b      0 235 0  0 0 1
fill_0     0 310 40 0 0 0
fill_1     1 321 40 0 2 0
fill_2     2 052 40 0 0 0
fill_3     3 1a3 40 0 1 0
stall_4    0 2c6 3  0 4 0
err_line   1 0f7 6  1 2 0
err_again  2 0f7 3  0 0 0
hit_0      3 310 0  0 5 1
hit_1      1 321 0  0 3 1
hit_err    0 0f7 0  0 2 1
hit_stall  2 2c6 0  0 0 1

// File: tests/icache_tb.sv
// each line of tests/icache_input.txt drives one fetch
// fetches run one after another, the memory model answers refills in request order
// a line fetched again waits until every earlier response has arrived
`include "icache_params.svh"

module icache_tb;

    localparam int period    = 100;
    localparam int skew      = 10;
    localparam int max_tests = 64;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      fetch_req_i;
    logic [`ICACHE_ID_W-1:0]   fetch_id_i;
    logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
    logic                      fetch_ack_o;
    logic                      mem_req_o;
    logic [`ICACHE_ADDR_W-1:0] mem_addr_o;
    logic [`ICACHE_PEND_W-1:0] mem_idx_o;
    logic                      mem_ack_i;
    logic                      mem_rsp_req_i;
    logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i;
    logic                      mem_rsp_err_i;
    logic [`ICACHE_PEND_W-1:0] mem_rsp_idx_i;
    logic                      mem_rsp_ack_o;
    logic                      rsp_req_o;
    logic [`ICACHE_LINE_W-1:0] rsp_data_o;
    logic                      rsp_err_o;
    logic [`ICACHE_IDS-1:0]    rsp_mask_o;
    logic                      rsp_ack_i;

    string name_t [max_tests];
    int    id_t [max_tests];
    int    addr_t [max_tests];
    int    mdelay_t [max_tests];
    int    err_t [max_tests];
    int    ackd_t [max_tests];
    int    kind_t [max_tests];
    int    num_tests = 0;
    int    cur_mdelay = 0;
    int    cur_err = 0;
    int    cur_ackd = 0;

    // refills in flight inside the memory model are kept oldest first
    logic [`ICACHE_ADDR_W-1:0] ref_addr_q [$];
    logic [`ICACHE_PEND_W-1:0] ref_idx_q [$];
    logic                      ref_err_q [$];
    time                       ref_due_q [$];

    icache_top dut (.*);

    icache_checker chk (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_ack_i   (fetch_ack_o),
        .mem_req_i     (mem_req_o),
        .mem_addr_i    (mem_addr_o),
        .mem_idx_i     (mem_idx_o),
        .mem_rsp_req_i (mem_rsp_req_i),
        .mem_rsp_idx_i (mem_rsp_idx_i),
        .rsp_req_i     (rsp_req_o),
        .rsp_data_i    (rsp_data_o),
        .rsp_err_i     (rsp_err_o),
        .rsp_mask_i    (rsp_mask_o)
    );

    initial clk_i = 1'b0;
    always #(period / 2) clk_i = ~clk_i;

    task automatic load_tests();
        int    fd;
        int    n;
        int    count;
        string line;
        string nm;
        int    id, addr, md, er, ad, kd;
        count = 0;
        fd = $fopen("tests/icache_input.txt", "r");
        if (fd != 0) begin
            n = $fgets(line, fd);
            while (n != 0 && count < max_tests) begin
                // comment lines fail the scan and are skipped
                if ($sscanf(line, "%s %d %h %d %d %d %d", nm, id, addr, md, er, ad, kd) == 7) begin
                    name_t[count]   = nm;
                    id_t[count]     = id;
                    addr_t[count]   = addr;
                    mdelay_t[count] = md;
                    err_t[count]    = er;
                    ackd_t[count]   = ad;
                    kind_t[count]   = kd;
                    count++;
                end
                n = $fgets(line, fd);
            end
            $fclose(fd);
        end
        num_tests = count;
    endtask

    task automatic run_fetch(input int t);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < t; i++)
            if (addr_t[i] == addr_t[t])
                seen = 1'b1;
        if (seen && kind_t[t] != 2)
            while (chk.open_count() != 0)
                @(posedge clk_i);
        @(posedge clk_i);
        #skew;
        cur_mdelay = mdelay_t[t];
        cur_err    = err_t[t];
        cur_ackd   = ackd_t[t];
        chk.start_test(t, name_t[t], 2'(id_t[t]), 12'(addr_t[t]), err_t[t] != 0, kind_t[t]);
        fetch_id_i   = 2'(id_t[t]);
        fetch_addr_i = 12'(addr_t[t]);
        fetch_req_i  = 1'b1;
        do @(posedge clk_i); while (!fetch_ack_o);
        #skew fetch_req_i = 1'b0;
        do @(posedge clk_i); while (fetch_ack_o);
    endtask

    initial begin
        rst_ni       = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_id_i   = '0;
        fetch_addr_i = '0;
        load_tests();
        repeat (8) @(posedge clk_i);
        #skew rst_ni = 1'b1;
        if (num_tests == 0) begin
            $display("no tests could be read from tests/icache_input.txt");
            $display("Test failures found");
        end else begin
            for (int t = 0; t < num_tests; t++)
                run_fetch(t);
            while (chk.open_count() != 0)
                @(posedge clk_i);
            repeat (5) @(posedge clk_i);
            chk.print_counts();
            if (chk.failed == 0 && chk.errors == 0 && chk.passed == num_tests)
                $display("All tests passed!");
            else
                $display("Test failures found");
        end
        $finish;
    end

    // refill requests are acked at once and answered after the delay of the fetch
    initial begin : mem_requests
        int jitter;
        mem_ack_i = 1'b0;
        void'($urandom(22246));
        forever begin
            @(posedge clk_i);
            if (mem_req_o && !mem_ack_i) begin
                jitter = int'($urandom % 4);
                ref_addr_q.push_back(mem_addr_o);
                ref_idx_q.push_back(mem_idx_o);
                ref_err_q.push_back(cur_err != 0);
                ref_due_q.push_back($time + time'((cur_mdelay + jitter) * period));
                #skew mem_ack_i = 1'b1;
                do @(posedge clk_i); while (mem_req_o);
                #skew mem_ack_i = 1'b0;
            end
        end
    end

    initial begin : mem_responses
        mem_rsp_req_i  = 1'b0;
        mem_rsp_data_i = '0;
        mem_rsp_err_i  = 1'b0;
        mem_rsp_idx_i  = '0;
        forever begin
            @(posedge clk_i);
            if (ref_due_q.size() > 0 && $time >= ref_due_q[0]) begin
                #skew;
                mem_rsp_data_i = chk.line_of(ref_addr_q[0]);
                mem_rsp_err_i  = ref_err_q[0];
                mem_rsp_idx_i  = ref_idx_q[0];
                mem_rsp_req_i  = 1'b1;
                do @(posedge clk_i); while (!mem_rsp_ack_o);
                #skew mem_rsp_req_i = 1'b0;
                do @(posedge clk_i); while (mem_rsp_ack_o);
                void'(ref_addr_q.pop_front());
                void'(ref_idx_q.pop_front());
                void'(ref_err_q.pop_front());
                void'(ref_due_q.pop_front());
            end
        end
    end

    // the fetch response is acked after the ack delay of the current test
    initial begin : rsp_acks
        int wait_cycles;
        rsp_ack_i = 1'b0;
        forever begin
            @(posedge clk_i);
            if (rsp_req_o && !rsp_ack_i) begin
                wait_cycles = cur_ackd;
                repeat (wait_cycles) @(posedge clk_i);
                #skew rsp_ack_i = 1'b1;
                do @(posedge clk_i); while (rsp_req_o);
                #skew rsp_ack_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (num_tests > 0);
        #(num_tests * 200 * period);
        $display("watchdog expired after %0d cycles with tests still open", num_tests * 200);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog/icache_if.sv
// lookup and table results for the registered fetch address, plus commands
// commands take effect at the next clock edge
`include "icache_params.svh"

interface icache_lookup_if;

    icache_pkg::line_addr_u    addr;
    logic                      addr_valid;
    icache_pkg::lookup_res_t   lres;
    icache_pkg::table_res_t    tres;

    logic                      push_en;
    logic                      push_init;
    logic [`ICACHE_PEND_W-1:0] push_idx;
    logic [`ICACHE_IDS-1:0]    push_mask;

    logic                      pop_en;
    logic [`ICACHE_PEND_W-1:0] pop_idx;
    icache_pkg::pending_t      pop_entry;

    logic                      wr_en;
    icache_pkg::line_addr_u    wr_addr;
    logic [`ICACHE_LINE_W-1:0] wr_data;

    modport front (
        input  addr, addr_valid, push_en, push_init, push_idx, push_mask,
        input  pop_en, pop_idx, wr_en, wr_addr, wr_data,
        output lres, tres, pop_entry
    );

    modport ctrl (
        output addr, addr_valid, push_en, push_init, push_idx, push_mask,
        output pop_en, pop_idx, wr_en, wr_addr, wr_data,
        input  lres, tres, pop_entry
    );

endinterface

// File: verilog/icache_lookup.sv
// tag and data arrays, two ways per set, read combinationally
// replacement takes an invalid way first, otherwise a 3-bit LFSR picks one
`include "icache_params.svh"

module icache_lookup (
    input  logic          clk_i,
    input  logic          rst_ni,
    icache_lookup_if.front lu
);

    localparam int sets = 1 << `ICACHE_SET_W;

    logic [`ICACHE_WAYS-1:0]   valid_q [sets];
    logic [`ICACHE_TAG_W-1:0]  tag_q   [sets][`ICACHE_WAYS];
    logic [`ICACHE_LINE_W-1:0] data_q  [sets][`ICACHE_WAYS];

    logic [`ICACHE_WAYS-1:0]   hit_way;
    logic [`ICACHE_SET_W-1:0]  rd_set;
    logic [`ICACHE_SET_W-1:0]  wr_set;
    logic [`ICACHE_WAY_W-1:0]  victim;
    logic [2:0]                lfsr_q;

    assign rd_set = lu.addr.split.set;
    assign wr_set = lu.wr_addr.split.set;

    always_comb begin
        lu.lres = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_way[w] = lu.addr_valid && valid_q[rd_set][w]
                         && tag_q[rd_set][w] == lu.addr.split.tag;
            if (hit_way[w])
                lu.lres.data = data_q[rd_set][w];
        end
        lu.lres.hit = |hit_way;

        // scan downwards so the lowest invalid way wins over the LFSR
        victim = lfsr_q[`ICACHE_WAY_W-1:0];
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[wr_set][w])
                victim = w[`ICACHE_WAY_W-1:0];
        end
        lu.lres.way = victim;
    end

    // the LFSR only advances on a line write, so eviction order follows refills
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < sets; s++)
                valid_q[s] <= '0;
            lfsr_q <= 3'b001;
        end else if (lu.wr_en) begin
            valid_q[wr_set][victim] <= 1'b1;
            lfsr_q <= {lfsr_q[1:0], lfsr_q[2] ^ lfsr_q[1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (lu.wr_en) begin
            tag_q[wr_set][victim]  <= lu.wr_addr.split.tag;
            data_q[wr_set][victim] <= lu.wr_data;
        end
    end

    // a line is only refilled after a miss, so it never sits in both ways
    one_way_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lu.addr_valid |-> $onehot0(hit_way));

endmodule

// File: verilog/icache_params.svh
// sizes of the instruction cache, checked only at this one configuration
// the line address carries no word offset, one response is a whole line
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// line address and line payload
`define ICACHE_ADDR_W 12
`define ICACHE_LINE_W 64

// geometry, four sets of two ways
`define ICACHE_SET_W 2
`define ICACHE_WAYS 2
`define ICACHE_WAY_W 1
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_SET_W)

// fetch ids travel as a one-hot mask in responses
`define ICACHE_IDS 4
`define ICACHE_ID_W 2

// table of refills in flight
`define ICACHE_PENDING 4
`define ICACHE_PEND_W 2

`endif

// File: verilog/icache_pkg.sv
// types shared by the cache arrays, the refill table and the controller
// widths come from the params header
`include "icache_params.svh"

package icache_pkg;

    // the flat view is compared and sent to memory, the split view indexes the arrays
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] flat;
        struct packed {
            logic [`ICACHE_TAG_W-1:0] tag;
            logic [`ICACHE_SET_W-1:0] set;
        } split;
    } line_addr_u;

    // one refill in flight and the fetch ids waiting on it
    typedef struct packed {
        logic                    valid;
        line_addr_u              addr;
        logic [`ICACHE_IDS-1:0]  idmask;
    } pending_t;

    // way is the victim for the set currently being written
    typedef struct packed {
        logic                     hit;
        logic [`ICACHE_LINE_W-1:0] data;
        logic [`ICACHE_WAY_W-1:0]  way;
    } lookup_res_t;

    typedef struct packed {
        logic                      match;
        logic [`ICACHE_PEND_W-1:0] match_idx;
        logic                      free;
        logic [`ICACHE_PEND_W-1:0] free_idx;
    } table_res_t;

endpackage

// File: verilog/icache_refill_ctrl.sv
// fetch, refill request, refill response and fetch response are all four-phase
// one fetch is resolved at a time, up to four refills stay in flight
// a hit wins the response port on a tie, the winner holds it until its ack falls
`include "icache_params.svh"

module icache_refill_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    icache_lookup_if.ctrl             lu,
    input  logic                      fetch_req_i,
    input  logic [`ICACHE_ID_W-1:0]   fetch_id_i,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
    output logic                      fetch_ack_o,
    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`ICACHE_PEND_W-1:0] mem_idx_o,
    input  logic                      mem_ack_i,
    input  logic                      mem_rsp_req_i,
    input  logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i,
    input  logic                      mem_rsp_err_i,
    input  logic [`ICACHE_PEND_W-1:0] mem_rsp_idx_i,
    output logic                      mem_rsp_ack_o,
    output logic                      rsp_req_o,
    output logic [`ICACHE_LINE_W-1:0] rsp_data_o,
    output logic                      rsp_err_o,
    output logic [`ICACHE_IDS-1:0]    rsp_mask_o,
    input  logic                      rsp_ack_i
);

    localparam logic [2:0] f_idle = 3'd0;
    localparam logic [2:0] f_look = 3'd1;
    localparam logic [2:0] f_mreq = 3'd2;
    localparam logic [2:0] f_hit  = 3'd3;
    localparam logic [2:0] f_ack  = 3'd4;
    localparam logic [1:0] r_idle = 2'd0;
    localparam logic [1:0] r_hold = 2'd1;
    localparam logic [1:0] r_send = 2'd2;
    localparam logic [1:0] r_ack  = 2'd3;

    logic [2:0]                f_state_q, f_state_d;
    logic [1:0]                r_state_q, r_state_d;
    logic [`ICACHE_ID_W-1:0]   f_id_q;
    icache_pkg::line_addr_u    f_addr_q;
    logic [`ICACHE_IDS-1:0]    f_mask;
    logic [`ICACHE_PEND_W-1:0] mem_idx_q;
    logic [`ICACHE_LINE_W-1:0] r_data_q;
    logic                      r_err_q;
    logic [`ICACHE_PEND_W-1:0] r_idx_q;
    logic                      rsp_req_q, rsp_err_q, sel_q, lock_q;
    logic [`ICACHE_LINE_W-1:0] rsp_data_q;
    logic [`ICACHE_IDS-1:0]    rsp_mask_q;
    logic                      hit_want, grant_hit, grant_ref, rsp_done;

    assign f_mask    = {{(`ICACHE_IDS - 1){1'b0}}, 1'b1} << f_id_q;
    assign hit_want  = f_state_q == f_look && lu.lres.hit;
    assign grant_hit = !lock_q && hit_want;
    assign grant_ref = !lock_q && !hit_want && r_state_q == r_hold;
    assign rsp_done  = rsp_req_q && rsp_ack_i;

    assign lu.addr       = f_addr_q;
    assign lu.addr_valid = f_state_q == f_look;
    assign lu.pop_en     = grant_ref;
    assign lu.pop_idx    = r_idx_q;
    // an errored refill still frees its entry but leaves the arrays untouched
    assign lu.wr_en      = grant_ref && !r_err_q;
    assign lu.wr_addr    = lu.pop_entry.addr;
    assign lu.wr_data    = r_data_q;

    assign fetch_ack_o   = f_state_q == f_ack;
    assign mem_req_o     = f_state_q == f_mreq;
    assign mem_addr_o    = f_addr_q.flat;
    assign mem_idx_o     = mem_idx_q;
    assign mem_rsp_ack_o = r_state_q == r_ack;
    assign rsp_req_o     = rsp_req_q;
    assign rsp_data_o    = rsp_data_q;
    assign rsp_err_o     = rsp_err_q;
    assign rsp_mask_o    = rsp_mask_q;

    // hit first, then merge, then allocate, otherwise stay in look and retry
    always_comb begin
        f_state_d    = f_state_q;
        lu.push_en   = 1'b0;
        lu.push_init = 1'b0;
        lu.push_idx  = lu.tres.match_idx;
        lu.push_mask = f_mask;
        case (f_state_q)
            f_idle: if (fetch_req_i) f_state_d = f_look;
            f_look: begin
                if (lu.lres.hit) begin
                    if (grant_hit)
                        f_state_d = f_hit;
                end else if (lu.tres.match) begin
                    lu.push_en = 1'b1;
                    f_state_d  = f_ack;
                end else if (lu.tres.free && !mem_ack_i) begin
                    // the previous refill request must have finished its ack phase
                    lu.push_en   = 1'b1;
                    lu.push_init = 1'b1;
                    lu.push_idx  = lu.tres.free_idx;
                    f_state_d    = f_mreq;
                end
            end
            f_mreq: if (mem_ack_i) f_state_d = f_ack;
            f_hit:  if (rsp_done && !sel_q) f_state_d = f_ack;
            f_ack:  if (!fetch_req_i) f_state_d = f_idle;
            default: f_state_d = f_idle;
        endcase
    end

    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            r_idle: if (mem_rsp_req_i) r_state_d = r_hold;
            r_hold: if (grant_ref) r_state_d = r_send;
            r_send: if (rsp_done && sel_q) r_state_d = r_ack;
            default: if (!mem_rsp_req_i) r_state_d = r_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            f_state_q <= f_idle;
            r_state_q <= r_idle;
            rsp_req_q <= 1'b0;
            sel_q     <= 1'b0;
            lock_q    <= 1'b0;
        end else begin
            f_state_q <= f_state_d;
            r_state_q <= r_state_d;
            // the lock drops only once ack is low again, closing the four phases
            if (grant_hit || grant_ref) begin
                lock_q    <= 1'b1;
                sel_q     <= grant_ref;
                rsp_req_q <= 1'b1;
            end else if (rsp_done) begin
                rsp_req_q <= 1'b0;
            end else if (lock_q && !rsp_req_q && !rsp_ack_i) begin
                lock_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (f_state_q == f_idle) begin
            f_id_q        <= fetch_id_i;
            f_addr_q.flat <= fetch_addr_i;
        end
        if (f_state_q == f_look)
            mem_idx_q <= lu.tres.free_idx;
        if (r_state_q == r_idle) begin
            r_data_q <= mem_rsp_data_i;
            r_err_q  <= mem_rsp_err_i;
            r_idx_q  <= mem_rsp_idx_i;
        end
        if (grant_hit) begin
            rsp_data_q <= lu.lres.data;
            rsp_err_q  <= 1'b0;
            rsp_mask_q <= f_mask;
        end else if (grant_ref) begin
            rsp_data_q <= r_data_q;
            rsp_err_q  <= r_err_q;
            rsp_mask_q <= lu.pop_entry.idmask;
        end
    end

    // every response carries the id of at least one waiting fetch
    rsp_names_ids: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_req_o |-> rsp_mask_o != '0);

endmodule

// File: verilog/icache_refill_table.sv
// table of refills in flight, searched by line address every cycle
// a push and a pop of the same entry in one cycle fold the pushed ids into the pop
`include "icache_params.svh"

module icache_refill_table (
    input  logic           clk_i,
    input  logic           rst_ni,
    icache_lookup_if.front lu
);

    icache_pkg::pending_t          entry_q [`ICACHE_PENDING];
    logic [`ICACHE_PENDING-1:0]    push_sel;
    logic [`ICACHE_PENDING-1:0]    pop_sel;

    always_comb begin
        for (int i = 0; i < `ICACHE_PENDING; i++) begin
            push_sel[i] = lu.push_en && lu.push_idx == i[`ICACHE_PEND_W-1:0];
            pop_sel[i]  = lu.pop_en && lu.pop_idx == i[`ICACHE_PEND_W-1:0];
        end
    end

    // a pop wins over a push to the same entry, the push ids leave with the pop
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `ICACHE_PENDING; i++)
                entry_q[i] <= '0;
        end else begin
            for (int i = 0; i < `ICACHE_PENDING; i++) begin
                if (push_sel[i]) begin
                    entry_q[i].valid  <= 1'b1;
                    entry_q[i].addr   <= lu.addr;
                    entry_q[i].idmask <= lu.push_init ? lu.push_mask
                                                      : entry_q[i].idmask | lu.push_mask;
                end
                if (pop_sel[i])
                    entry_q[i].valid <= 1'b0;
            end
        end
    end

    // lowest matching and lowest free index, found by scanning from the top
    always_comb begin
        lu.tres = '0;
        for (int i = `ICACHE_PENDING - 1; i >= 0; i--) begin
            if (lu.addr_valid && entry_q[i].valid
                && entry_q[i].addr.flat == lu.addr.flat) begin
                lu.tres.match     = 1'b1;
                lu.tres.match_idx = i[`ICACHE_PEND_W-1:0];
            end
            if (!entry_q[i].valid) begin
                lu.tres.free     = 1'b1;
                lu.tres.free_idx = i[`ICACHE_PEND_W-1:0];
            end
        end
    end

    always_comb begin
        lu.pop_entry = entry_q[lu.pop_idx];
        if (lu.push_en && lu.pop_en && lu.push_idx == lu.pop_idx)
            lu.pop_entry.idmask = lu.pop_entry.idmask | lu.push_mask;
    end

    // memory answers only for indices that were handed out with a refill request
    pop_of_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lu.pop_en |-> entry_q[lu.pop_idx].valid);

endmodule

// File: verilog/icache_top.sv
// two-way instruction cache with a table of four pending refills
// every external port is a four-phase req/ack handshake
`include "icache_params.svh"

module icache_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      fetch_req_i,
    input  logic [`ICACHE_ID_W-1:0]   fetch_id_i,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
    output logic                      fetch_ack_o,

    output logic                      mem_req_o,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`ICACHE_PEND_W-1:0] mem_idx_o,
    input  logic                      mem_ack_i,

    input  logic                      mem_rsp_req_i,
    input  logic [`ICACHE_LINE_W-1:0] mem_rsp_data_i,
    input  logic                      mem_rsp_err_i,
    input  logic [`ICACHE_PEND_W-1:0] mem_rsp_idx_i,
    output logic                      mem_rsp_ack_o,

    output logic                      rsp_req_o,
    output logic [`ICACHE_LINE_W-1:0] rsp_data_o,
    output logic                      rsp_err_o,
    output logic [`ICACHE_IDS-1:0]    rsp_mask_o,
    input  logic                      rsp_ack_i
);

    icache_lookup_if lu ();

    icache_lookup u_lookup (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .lu     (lu.front)
    );

    icache_refill_table u_table (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .lu     (lu.front)
    );

    icache_refill_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lu             (lu.ctrl),
        .fetch_req_i    (fetch_req_i),
        .fetch_id_i     (fetch_id_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_idx_o      (mem_idx_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rsp_req_i  (mem_rsp_req_i),
        .mem_rsp_data_i (mem_rsp_data_i),
        .mem_rsp_err_i  (mem_rsp_err_i),
        .mem_rsp_idx_i  (mem_rsp_idx_i),
        .mem_rsp_ack_o  (mem_rsp_ack_o),
        .rsp_req_o      (rsp_req_o),
        .rsp_data_o     (rsp_data_o),
        .rsp_err_o      (rsp_err_o),
        .rsp_mask_o     (rsp_mask_o),
        .rsp_ack_i      (rsp_ack_i)
    );

endmodule
